//--- dv/rs_model.svh
// Expected outputs of the station for one cycle
typedef struct packed {
  rs_pkg::rs_issue_t issue;
  logic              rs_free;
  logic              alu_rdy;
  logic              mem_rdy;
  logic              mult_rdy;
} expect_t;

// Model entry state as it stands after the last clock edge
logic             m_free [rs_pkg::RS_SZ];
logic             m_opa  [rs_pkg::RS_SZ];
logic             m_opb  [rs_pkg::RS_SZ];
rs_pkg::rs_inst_t m_inst [rs_pkg::RS_SZ];

function automatic void clear_entries();
  for (int i = 0; i < rs_pkg::RS_SZ; i++) begin
    m_free[i] = 1'b1;
    m_opa[i]  = 1'b0;
    m_opb[i]  = 1'b0;
    m_inst[i] = '0;
  end
endfunction

function automatic logic on_bus(
  input logic [rs_pkg::PRF_IDX-1:0]       tag,
  input rs_pkg::cdb_t [rs_pkg::CDB_W-1:0] bus
);
  logic seen;
  seen = 1'b0;
  for (int k = 0; k < rs_pkg::CDB_W; k++) begin
    if (bus[k].valid && bus[k].tag == tag) seen = 1'b1;
  end
  return seen;
endfunction

// 0 ALU, 1 memory, 2 multiplier
function automatic int class_of(input rs_pkg::rs_inst_t t);
  if (t.rd_mem || t.wr_mem) return 1;
  if (t.alu_op == rs_pkg::ALU_MULQ) return 2;
  return 0;
endfunction

function automatic logic any_entry_free();
  for (int i = 0; i < rs_pkg::RS_SZ; i++) begin
    if (m_free[i]) return 1'b1;
  end
  return 1'b0;
endfunction

function automatic expect_t expected_outputs(
  input rs_pkg::cdb_t [rs_pkg::CDB_W-1:0] bus,
  input logic                             af,
  input logic                             mf,
  input logic                             xf
);
  expect_t e;
  int      first [3];
  int      win;
  int      cls;
  e     = '0;
  first = '{-1, -1, -1};
  win   = -1;
  cls   = 0;
  for (int i = 0; i < rs_pkg::RS_SZ; i++) begin
    if (m_free[i]) begin
      e.rs_free = 1'b1;
    end else if ((m_opa[i] || on_bus(m_inst[i].prega, bus)) &&
                 (m_opb[i] || on_bus(m_inst[i].pregb, bus))) begin
      if (first[class_of(m_inst[i])] < 0) first[class_of(m_inst[i])] = i;  // Lowest ready
    end
  end
  e.alu_rdy  = first[0] >= 0;
  e.mem_rdy  = first[1] >= 0;
  e.mult_rdy = first[2] >= 0;
  if (af && e.alu_rdy) begin
    win = first[0];
    cls = 0;
  end else if (mf && e.mem_rdy) begin
    win = first[1];
    cls = 1;
  end else if (xf && e.mult_rdy) begin
    win = first[2];
    cls = 2;
  end
  if (win >= 0) begin
    e.issue.valid  = 1'b1;
    e.issue.fu     = rs_pkg::fu_class_t'(cls);
    e.issue.rs_idx = win[rs_pkg::RS_IDX-1:0];
    e.issue.inst   = m_inst[win];
  end
  return e;
endfunction

// State the DUT takes at the coming edge
function automatic void advance_entries(
  input expect_t                          e,
  input logic                             den,
  input rs_pkg::rs_inst_t                 dinst,
  input logic [rs_pkg::RS_SZ-1:0]         fl,
  input rs_pkg::cdb_t [rs_pkg::CDB_W-1:0] bus
);
  int slot;
  slot = -1;
  for (int i = 0; i < rs_pkg::RS_SZ; i++) begin
    if (den && m_free[i] && slot < 0) slot = i;
  end
  for (int i = 0; i < rs_pkg::RS_SZ; i++) begin
    if (fl[i] || (slot != i && e.issue.valid && e.issue.rs_idx == i)) begin
      m_free[i] = 1'b1;  // Flush wins over the dispatch
      m_opa[i]  = 1'b0;
      m_opb[i]  = 1'b0;
    end else if (slot == i) begin
      m_free[i] = 1'b0;
      m_inst[i] = dinst;
      m_opa[i]  = dinst.prega_valid || on_bus(dinst.prega, bus);
      m_opb[i]  = dinst.pregb_valid || on_bus(dinst.pregb, bus);
    end else if (!m_free[i]) begin
      m_opa[i] = m_opa[i] || on_bus(m_inst[i].prega, bus);
      m_opb[i] = m_opb[i] || on_bus(m_inst[i].pregb, bus);
    end
  end
endfunction

//--- dv/rs_tb.sv
`default_nettype none

module rs_tb;

  localparam int          DIRECTED_CYCLES = 80;
  localparam int          RANDOM_CYCLES   = 3000;
  localparam int          CYCLE_LIMIT     = DIRECTED_CYCLES + RANDOM_CYCLES + 200;
  localparam logic [31:0] SEED            = 32'd76376;

  logic                             clk;
  logic                             reset;
  logic                             dispatch_en;
  rs_pkg::rs_inst_t                 dispatch_inst;
  rs_pkg::cdb_t [rs_pkg::CDB_W-1:0] cdb;
  logic                             alu_free;
  logic                             mem_free;
  logic                             mult_free;
  logic [rs_pkg::RS_SZ-1:0]         flush;
  rs_pkg::rs_issue_t                issue;
  logic                             rs_free;
  logic                             alu_rdy;
  logic                             mem_rdy;
  logic                             mult_rdy;
  logic [31:0]                      lfsr;
  string                            test_name;
  int                               cycles;
  rs_pkg::rs_inst_t                 held [rs_pkg::RS_SZ];

  `include "rs_model.svh"

  rs_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .dispatch_en   (dispatch_en),
    .dispatch_inst (dispatch_inst),
    .cdb           (cdb),
    .alu_free      (alu_free),
    .mem_free      (mem_free),
    .mult_free     (mult_free),
    .flush         (flush),
    .issue         (issue),
    .rs_free       (rs_free),
    .alu_rdy       (alu_rdy),
    .mem_rdy       (mem_rdy),
    .mult_rdy      (mult_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string field, input logic [127:0] e,
                                 input logic [127:0] a);
    abort_run($sformatf("mismatch %s %s: expected %h actual %h", test_name, field, e, a));
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return r;
  endfunction

  // cls 0 ALU, 1 memory, 2 multiplier
  function automatic rs_pkg::rs_inst_t build_inst(input logic [5:0] a, input logic [5:0] b,
                                                  input logic va, input logic vb, input int cls);
    rs_pkg::rs_inst_t t;
    t             = '0;
    t.prega       = a;
    t.pregb       = b;
    t.prega_valid = va;
    t.pregb_valid = vb;
    t.pdest       = 6'(take_bits(6));
    t.ir          = take_bits(32);
    t.npc         = {take_bits(32), take_bits(32)};
    t.rob_idx     = 5'(take_bits(5));
    t.alu_op      = 5'(take_bits(5));
    if (cls != 2 && t.alu_op == rs_pkg::ALU_MULQ) t.alu_op = 5'h00;
    if (cls == 1) begin
      t.rd_mem = take_bits(1) != 0;
      t.wr_mem = !t.rd_mem;
    end
    if (cls == 2) t.alu_op = rs_pkg::ALU_MULQ;
    return t;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #10;
    dispatch_en = 1'b0;  // Strobes last one cycle
    flush       = '0;
    cdb         = '0;
  endtask

  task automatic dispatch(input rs_pkg::rs_inst_t t);
    dispatch_en   = 1'b1;
    dispatch_inst = t;
  endtask

  task automatic set_units(input logic a, input logic m, input logic x);
    alu_free  = a;
    mem_free  = m;
    mult_free = x;
  endtask

  // Direct look at the issue port once inputs have settled
  task automatic check_issue(input logic v, input int cls, input int idx,
                             input rs_pkg::rs_inst_t t);
    #1;
    assert (issue.valid === v) else report_mismatch("issue.valid", v, issue.valid);
    if (v) begin
      assert (issue.fu == rs_pkg::fu_class_t'(cls)) else report_mismatch("issue.fu", cls, issue.fu);
      assert (issue.rs_idx == idx) else report_mismatch("issue.rs_idx", idx, issue.rs_idx);
      assert (issue.inst == t) else report_mismatch("issue.inst", t, issue.inst);
    end
  endtask

  always @(negedge clk) begin : compare
    expect_t e;
    if (reset !== 1'b0) begin
      clear_entries();
    end else begin
      e = expected_outputs(cdb, alu_free, mem_free, mult_free);
      assert (issue.valid === e.issue.valid)
        else report_mismatch("issue.valid", e.issue.valid, issue.valid);
      assert (rs_free === e.rs_free) else report_mismatch("rs_free", e.rs_free, rs_free);
      assert (alu_rdy === e.alu_rdy) else report_mismatch("alu_rdy", e.alu_rdy, alu_rdy);
      assert (mem_rdy === e.mem_rdy) else report_mismatch("mem_rdy", e.mem_rdy, mem_rdy);
      assert (mult_rdy === e.mult_rdy) else report_mismatch("mult_rdy", e.mult_rdy, mult_rdy);
      if (e.issue.valid) begin
        assert (issue.fu == e.issue.fu) else report_mismatch("issue.fu", e.issue.fu, issue.fu);
        assert (issue.rs_idx == e.issue.rs_idx)
          else report_mismatch("issue.rs_idx", e.issue.rs_idx, issue.rs_idx);
        assert (issue.inst == e.issue.inst)
          else report_mismatch("issue.inst", e.issue.inst, issue.inst);
      end
      advance_entries(e, dispatch_en, dispatch_inst, flush, cdb);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) abort_run($sformatf("timeout after %0d cycles", cycles));
  end

  initial begin
    lfsr          = SEED;
    cycles        = 0;
    test_name     = "reset";
    reset         = 1'b1;
    dispatch_en   = 1'b0;
    dispatch_inst = '0;
    cdb           = '0;
    flush         = '0;
    set_units(1'b1, 1'b1, 1'b1);
    repeat (2) @(posedge clk);
    #10;
    reset = 1'b0;

    held[0] = build_inst(6'd1, 6'd2, 1'b1, 1'b1, 0);
    dispatch(held[0]);
    check_issue(1'b0, 0, 0, '0);
    assert (rs_free && !alu_rdy && !mem_rdy && !mult_rdy)
      else abort_run("station not empty after reset");
    next_cycle();
    check_issue(1'b1, 0, 0, held[0]);  // Earliest issue, entry 0
    next_cycle();

    test_name = "wakeup";
    held[0] = build_inst(6'd5, 6'd9, 1'b0, 1'b0, 0);
    dispatch(held[0]);
    cdb[1] = '{valid: 1'b1, tag: 6'd5};  // Caught while allocating
    next_cycle();
    cdb[1] = '{valid: 1'b1, tag: 6'd7};
    check_issue(1'b0, 0, 0, '0);
    next_cycle();
    cdb[0] = '{valid: 1'b1, tag: 6'd9};
    check_issue(1'b1, 0, 0, held[0]);  // Bypass
    next_cycle();

    test_name = "routing";
    set_units(1'b0, 1'b0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      held[i] = build_inst(6'd0, 6'd0, 1'b1, 1'b1, i);
      dispatch(held[i]);
      next_cycle();
    end
    set_units(1'b1, 1'b1, 1'b1);
    for (int i = 0; i < 3; i++) begin
      check_issue(1'b1, i, i, held[i]);
      next_cycle();
    end
    held[0] = build_inst(6'd3, 6'd4, 1'b1, 1'b1, 2);
    dispatch(held[0]);
    check_issue(1'b0, 0, 0, '0);
    next_cycle();
    check_issue(1'b1, 2, 0, held[0]);  // ALU and memory idle, turn passes on
    next_cycle();

    test_name = "backpressure";
    set_units(1'b0, 1'b0, 1'b0);
    for (int i = 0; i < rs_pkg::RS_SZ; i++) begin
      dispatch(build_inst(6'd0, 6'd0, 1'b1, 1'b1, int'(take_bits(2)) % 3));
      next_cycle();
    end
    check_issue(1'b0, 0, 0, '0);
    assert (rs_free == 1'b0) else report_mismatch("rs_free", 1'b0, rs_free);
    next_cycle();
    set_units(1'b1, 1'b1, 1'b1);
    #1;
    while (alu_rdy || mem_rdy || mult_rdy) begin
      next_cycle();
      #1;
    end
    assert (rs_free == 1'b1) else report_mismatch("rs_free", 1'b1, rs_free);
    next_cycle();

    test_name = "flush";
    set_units(1'b0, 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      held[i] = build_inst(6'd0, 6'd0, 1'b1, 1'b1, 0);
      dispatch(held[i]);
      next_cycle();
    end
    flush = 8'b0000_0101;
    next_cycle();
    held[0] = build_inst(6'd0, 6'd0, 1'b1, 1'b1, 0);
    dispatch(held[0]);
    next_cycle();
    held[2] = build_inst(6'd0, 6'd0, 1'b1, 1'b1, 0);
    dispatch(held[2]);
    next_cycle();
    set_units(1'b1, 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      check_issue(1'b1, 0, i, held[i]);
      next_cycle();
    end
    check_issue(1'b0, 0, 0, '0);
    next_cycle();

    test_name = "random";
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      set_units(take_bits(2) != 0, take_bits(2) != 0, take_bits(2) != 0);
      for (int k = 0; k < rs_pkg::CDB_W; k++) begin
        cdb[k].valid = take_bits(1) != 0;
        cdb[k].tag   = 6'(take_bits(4));
      end
      if (any_entry_free() && take_bits(1)) begin
        dispatch(build_inst(6'(take_bits(4)), 6'(take_bits(4)), take_bits(2) == 0,
                            take_bits(2) == 0, int'(take_bits(2)) % 3));
      end
      if (take_bits(5) == 0) flush = 8'(take_bits(8));  // Rare recovery
      next_cycle();
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+dv
logic/rs_pkg.sv
logic/prio_select.sv
logic/rs_entry.sv
logic/issue_select.sv
logic/rs_top.sv
dv/rs_tb.sv

//--- logic/issue_select.sv
`default_nettype none

module issue_select (
  input  wire  [rs_pkg::RS_SZ-1:0]                   alu_gnt,
  input  wire  [rs_pkg::RS_SZ-1:0]                   mem_gnt,
  input  wire  [rs_pkg::RS_SZ-1:0]                   mult_gnt,
  input  wire                                        alu_any,
  input  wire                                        mem_any,
  input  wire                                        mult_any,
  input  wire                                        alu_free,
  input  wire                                        mem_free,
  input  wire                                        mult_free,
  input  wire rs_pkg::rs_inst_t [rs_pkg::RS_SZ-1:0]  entry_inst,
  output rs_pkg::rs_issue_t                          issue,
  output logic [rs_pkg::RS_SZ-1:0]                   issue_sel
);

  logic                      chosen;
  rs_pkg::fu_class_t         fu;
  logic [rs_pkg::RS_IDX-1:0] idx;
  rs_pkg::rs_inst_t          payload;

  // First class that is free and has work
  always_comb begin
    issue_sel = '0;
    fu        = rs_pkg::alu;
    chosen    = 1'b0;
    if (alu_free && alu_any) begin
      issue_sel = alu_gnt;
      fu        = rs_pkg::alu;
      chosen    = 1'b1;
    end else if (mem_free && mem_any) begin
      issue_sel = mem_gnt;
      fu        = rs_pkg::mem;
      chosen    = 1'b1;
    end else if (mult_free && mult_any) begin
      issue_sel = mult_gnt;
      fu        = rs_pkg::mult;
      chosen    = 1'b1;
    end
  end

  // One-hot to index
  always_comb begin
    idx = '0;
    for (int i = 0; i < rs_pkg::RS_SZ; i++) begin
      if (issue_sel[i]) begin
        idx = i[rs_pkg::RS_IDX-1:0];
      end
    end
  end

  // All zero when nothing goes out
  always_comb begin
    payload = '0;
    for (int i = 0; i < rs_pkg::RS_SZ; i++) begin
      if (issue_sel[i]) begin
        payload = entry_inst[i];
      end
    end
  end

  always_comb begin
    issue.valid  = chosen;
    issue.fu     = fu;
    issue.rs_idx = idx;
    issue.inst   = payload;
  end

endmodule

`default_nettype wire

//--- logic/prio_select.sv
`default_nettype none

// Lowest index wins
module prio_select #(
  parameter int WIDTH = 8
) (
  input  wire  [WIDTH-1:0] req,
  input  wire              en,
  output logic [WIDTH-1:0] gnt,
  output logic             any
);

  always_comb begin
    gnt = '0;
    if (en) begin
      // Walk downward so the lowest request is written last
      for (int i = WIDTH - 1; i >= 0; i--) begin
        if (req[i]) begin
          gnt    = '0;
          gnt[i] = 1'b1;
        end
      end
    end
  end

  assign any = |req;  // Ignores en

  gnt_onehot: assert final ($onehot0(gnt) && ((gnt & ~req) == '0));

endmodule

`default_nettype wire

//--- logic/rs_entry.sv
`default_nettype none

module rs_entry (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   flush,
  input  wire                                   alloc,
  input  wire                                   issue_sel,
  input  wire rs_pkg::rs_inst_t                 inst_in,
  input  wire rs_pkg::cdb_t [rs_pkg::CDB_W-1:0] cdb,
  output logic                                  free,
  output logic                                  alu_rdy,
  output logic                                  mem_rdy,
  output logic                                  mult_rdy,
  output rs_pkg::rs_inst_t                      inst
);

  logic opa_rdy;     // Latched operand state
  logic opb_rdy;
  logic opa_hit;     // Broadcast matches stored tag
  logic opb_hit;
  logic opa_hit_in;  // Broadcast matches dispatch tag
  logic opb_hit_in;
  logic opa_now;
  logic opb_now;
  logic ops_rdy;
  logic is_mem;
  logic is_mult;

  // Any valid CDB slot carrying this tag
  function automatic logic tag_hit(
    input logic [rs_pkg::PRF_IDX-1:0]      tag,
    input rs_pkg::cdb_t [rs_pkg::CDB_W-1:0] bus
  );
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < rs_pkg::CDB_W; k++) begin
      if (bus[k].valid && (bus[k].tag == tag)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  assign opa_hit    = tag_hit(inst.prega, cdb);
  assign opb_hit    = tag_hit(inst.pregb, cdb);
  assign opa_hit_in = tag_hit(inst_in.prega, cdb);
  assign opb_hit_in = tag_hit(inst_in.pregb, cdb);

  // Wakeup bypass
  assign opa_now = opa_rdy | opa_hit;
  assign opb_now = opb_rdy | opb_hit;
  assign ops_rdy = !free && opa_now && opb_now;

  assign is_mem  = inst.rd_mem | inst.wr_mem;
  assign is_mult = !is_mem && (inst.alu_op == rs_pkg::ALU_MULQ);

  assign mem_rdy  = ops_rdy && is_mem;
  assign mult_rdy = ops_rdy && is_mult;
  assign alu_rdy  = ops_rdy && !is_mem && !is_mult;

  always_ff @(posedge clk) begin
    if (reset) begin
      free    <= 1'b1;
      opa_rdy <= 1'b0;
      opb_rdy <= 1'b0;
    end else if (flush) begin  // Beats alloc and issue
      free    <= 1'b1;
      opa_rdy <= 1'b0;
      opb_rdy <= 1'b0;
    end else if (alloc) begin
      free    <= 1'b0;
      opa_rdy <= inst_in.prega_valid | opa_hit_in;
      opb_rdy <= inst_in.pregb_valid | opb_hit_in;
    end else if (issue_sel) begin
      free    <= 1'b1;
      opa_rdy <= 1'b0;
      opb_rdy <= 1'b0;
    end else if (!free) begin
      opa_rdy <= opa_now;
      opb_rdy <= opb_now;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      inst <= inst_in;
    end
  end

  rdy_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0({alu_rdy, mem_rdy, mult_rdy})
  );

  // The selector upstream must only pick occupied slots
  sel_occupied: assert property (
    @(posedge clk) disable iff (reset)
    issue_sel |-> !free
  );

endmodule

`default_nettype wire

//--- logic/rs_pkg.sv
`default_nettype none

package rs_pkg;

  // Sizes
  localparam int PRF_IDX = 6;  // Physical register tag width
  localparam int ROB_IDX = 5;  // ROB index width
  localparam int RS_SZ   = 8;  // Station entries
  localparam int RS_IDX  = 3;  // Entry index width
  localparam int CDB_W   = 2;  // Broadcasts per cycle

  // Alpha multiply opcode, routed to the multiplier
  localparam logic [4:0] ALU_MULQ = 5'h0b;

  // Renamed instruction as it leaves dispatch
  typedef struct packed {
    logic [PRF_IDX-1:0] pdest;  // Destination tag
    logic [PRF_IDX-1:0] prega;
    logic [PRF_IDX-1:0] pregb;
    logic               prega_valid;  // Operand A already in PRF
    logic               pregb_valid;  // Operand B already in PRF
    logic [4:0]         alu_op;
    logic               rd_mem;
    logic               wr_mem;
    logic [31:0]        ir;
    logic [63:0]        npc;
    logic [ROB_IDX-1:0] rob_idx;
  } rs_inst_t;

  // One common data bus broadcast
  typedef struct packed {
    logic               valid;
    logic [PRF_IDX-1:0] tag;
  } cdb_t;

  // Functional-unit classes
  typedef enum logic [1:0] {
    alu  = 2'd0,
    mem  = 2'd1,
    mult = 2'd2
  } fu_class_t;

  // Packet toward the functional units
  typedef struct packed {
    logic              valid;
    fu_class_t         fu;
    logic [RS_IDX-1:0] rs_idx;  // Entry being released
    rs_inst_t          inst;
  } rs_issue_t;

endpackage

`default_nettype wire

//--- logic/rs_top.sv
`default_nettype none

module rs_top (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   dispatch_en,
  input  wire rs_pkg::rs_inst_t                 dispatch_inst,
  input  wire rs_pkg::cdb_t [rs_pkg::CDB_W-1:0] cdb,
  input  wire                                   alu_free,
  input  wire                                   mem_free,
  input  wire                                   mult_free,
  input  wire  [rs_pkg::RS_SZ-1:0]              flush,
  output rs_pkg::rs_issue_t                     issue,
  output logic                                  rs_free,
  output logic                                  alu_rdy,
  output logic                                  mem_rdy,
  output logic                                  mult_rdy
);

  wire [rs_pkg::RS_SZ-1:0] entry_free;
  wire [rs_pkg::RS_SZ-1:0] entry_alu_rdy;
  wire [rs_pkg::RS_SZ-1:0] entry_mem_rdy;
  wire [rs_pkg::RS_SZ-1:0] entry_mult_rdy;
  wire rs_pkg::rs_inst_t [rs_pkg::RS_SZ-1:0] entry_inst;

  logic [rs_pkg::RS_SZ-1:0] alloc_gnt;  // Slot taking the dispatch
  logic [rs_pkg::RS_SZ-1:0] alu_gnt;
  logic [rs_pkg::RS_SZ-1:0] mem_gnt;
  logic [rs_pkg::RS_SZ-1:0] mult_gnt;
  logic [rs_pkg::RS_SZ-1:0] issue_sel;

  prio_select #(.WIDTH(rs_pkg::RS_SZ)) alloc_sel (
    .req (entry_free),
    .en  (dispatch_en),
    .gnt (alloc_gnt),
    .any (rs_free)
  );

  prio_select #(.WIDTH(rs_pkg::RS_SZ)) alu_sel (
    .req (entry_alu_rdy),
    .en  (alu_free),
    .gnt (alu_gnt),
    .any (alu_rdy)
  );

  prio_select #(.WIDTH(rs_pkg::RS_SZ)) mem_sel (
    .req (entry_mem_rdy),
    .en  (mem_free),
    .gnt (mem_gnt),
    .any (mem_rdy)
  );

  prio_select #(.WIDTH(rs_pkg::RS_SZ)) mult_sel (
    .req (entry_mult_rdy),
    .en  (mult_free),
    .gnt (mult_gnt),
    .any (mult_rdy)
  );

  issue_select u_issue_select (
    .alu_gnt    (alu_gnt),
    .mem_gnt    (mem_gnt),
    .mult_gnt   (mult_gnt),
    .alu_any    (alu_rdy),
    .mem_any    (mem_rdy),
    .mult_any   (mult_rdy),
    .alu_free   (alu_free),
    .mem_free   (mem_free),
    .mult_free  (mult_free),
    .entry_inst (entry_inst),
    .issue      (issue),
    .issue_sel  (issue_sel)
  );

  for (genvar i = 0; i < rs_pkg::RS_SZ; i++) begin : g_entry
    rs_entry u_entry (
      .clk       (clk),
      .reset     (reset),
      .flush     (flush[i]),
      .alloc     (alloc_gnt[i]),
      .issue_sel (issue_sel[i]),
      .inst_in   (dispatch_inst),
      .cdb       (cdb),
      .free      (entry_free[i]),
      .alu_rdy   (entry_alu_rdy[i]),
      .mem_rdy   (entry_mem_rdy[i]),
      .mult_rdy  (entry_mult_rdy[i]),
      .inst      (entry_inst[i])
    );
  end

  no_dispatch_full: assert property (
    @(posedge clk) disable iff (reset)
    dispatch_en |-> rs_free
  );

endmodule

`default_nettype wire
